// File: rv32m_consts.svh
// Word size, iteration count and special-case results for the RV32M execute block and its testbench
`ifndef RV32M_CONSTS_SVH
`define RV32M_CONSTS_SVH

// Data word width in bits
`define RV32M_WORD_SIZE 32

// Iterations per unit operation
// Both units retire two bits per cycle over the 32-bit word
`define RV32M_STEPS 16

// Quotient for division by zero
// Both DIV and DIVU return all ones
`define RV32M_DIVZ_QUOT 32'hFFFF_FFFF

// Quotient for signed overflow
// The most negative word divided by minus one
`define RV32M_OVF_QUOT 32'h8000_0000

// Remainder for signed overflow
// Zero, the wrapped quotient leaves nothing over
`define RV32M_OVF_REM 32'h0000_0000

`endif

// File: rv32m_pkg.sv
// Data, operation and unit state types shared by the RV32M RTL and testbench, imported by wildcard
`include "rv32m_consts.svh"

package rv32m_pkg;

    // One data word, operand or result
    typedef logic [`RV32M_WORD_SIZE-1:0] word_t;

    // Full 64-bit product
    typedef logic [2*`RV32M_WORD_SIZE-1:0] dword_t;

    // Signedness per operand
    // Bit 1 set when operand A is signed, bit 0 when operand B is signed
    typedef logic [1:0] sign_sel_t;

    // RV32M operations in funct3 order
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } rv32m_op_t;

    // Functional unit FSM, shared by multiplier and divider
    // DONE holds the result until the next start
    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        SIGN_FIX,
        DONE
    } unit_state_t;

endpackage

// File: shift_add_multiplier.sv
// Iterative 32x32 shift-add multiplier, two bits per cycle, launched by a start pulse
`timescale 1ns/1ps
`include "rv32m_consts.svh"

module shift_add_multiplier import rv32m_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      start,
    input  word_t     multiplicand,
    input  word_t     multiplier,
    input  sign_sel_t is_signed,
    output dword_t    product,
    output logic      finished
);

    localparam int STEP_W = $clog2(`RV32M_STEPS);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`RV32M_STEPS - 1);

    unit_state_t state;
    logic [STEP_W-1:0] step;
    logic accept;

    // Accumulator and shifting operands
    dword_t acc;
    dword_t mcand_sh;
    word_t mplier;
    logic prod_neg;

    // Operand magnitudes at start
    logic a_neg;
    logic b_neg;
    word_t a_mag;
    word_t b_mag;

    // Multiples of the shifted multiplicand
    dword_t mcand_x2;
    dword_t mcand_x3;
    dword_t partial;

    // Start only taken when not busy
    assign accept = start && ((state == IDLE) || (state == DONE));

    assign a_neg = is_signed[1] && multiplicand[`RV32M_WORD_SIZE-1];
    assign b_neg = is_signed[0] && multiplier[`RV32M_WORD_SIZE-1];
    assign a_mag = a_neg ? -multiplicand : multiplicand;
    assign b_mag = b_neg ? -multiplier : multiplier;

    assign mcand_x2 = mcand_sh << 1;
    assign mcand_x3 = mcand_sh + mcand_x2;

    // Two multiplier bits pick 0, 1, 2 or 3 times the multiplicand
    always_comb begin
        case (mplier[1:0])
            2'b00:   partial = '0;
            2'b01:   partial = mcand_sh;
            2'b10:   partial = mcand_x2;
            default: partial = mcand_x3;
        endcase
    end

    // Control FSM and accumulator
    // Accumulator cleared at reset so product reads zero
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            step  <= '0;
            acc   <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (accept) begin
                        state <= BUSY;
                        step  <= '0;
                        acc   <= '0;
                    end
                end
                BUSY: begin
                    acc  <= acc + partial;
                    step <= step + 1'b1;
                    if (step == LAST_STEP) begin
                        state <= SIGN_FIX;
                    end
                end
                SIGN_FIX: begin
                    // Magnitude product back to two's complement
                    if (prod_neg) begin
                        acc <= -acc;
                    end
                    state <= DONE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Operand shifters, multiplicand moves left as multiplier moves right
    always_ff @(posedge CLK) begin
        if (accept) begin
            mcand_sh <= dword_t'(a_mag);
            mplier   <= b_mag;
            prod_neg <= a_neg ^ b_neg;
        end else if (state == BUSY) begin
            mcand_sh <= mcand_sh << 2;
            mplier   <= mplier >> 2;
        end
    end

    assign product  = acc;
    assign finished = (state == DONE);

endmodule

// File: radix4_divider.sv
// Radix-4 restoring divider for 32-bit words, two quotient bits per cycle, launched by a start pulse
`timescale 1ns/1ps
`include "rv32m_consts.svh"

module radix4_divider import rv32m_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  start,
    input  word_t dividend,
    input  word_t divisor,
    input  logic  is_signed,
    output word_t quotient,
    output word_t remainder,
    output logic  finished
);

    localparam int STEP_W = $clog2(`RV32M_STEPS);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`RV32M_STEPS - 1);
    // Partial remainder holds four times the divisor
    localparam int REM_W = `RV32M_WORD_SIZE + 2;

    typedef logic [REM_W-1:0] rem_t;

    unit_state_t state;
    logic [STEP_W-1:0] step;
    logic accept;

    // Dividend bits shift out the top, quotient bits shift in the bottom
    word_t qd;
    rem_t rem;
    rem_t d1;
    rem_t d2;
    rem_t d3;
    logic q_neg;
    logic r_neg;

    // Operand magnitudes at start
    logic dvd_neg;
    logic dvs_neg;
    word_t dvd_mag;
    word_t dvs_mag;

    // One radix-4 step
    rem_t rem_sh;
    rem_t rem_next;
    logic [1:0] q_digit;

    // Sign-corrected results
    word_t quot_fixed;
    word_t rem_fixed;

    assign accept = start && ((state == IDLE) || (state == DONE));

    assign dvd_neg = is_signed && dividend[`RV32M_WORD_SIZE-1];
    assign dvs_neg = is_signed && divisor[`RV32M_WORD_SIZE-1];
    assign dvd_mag = dvd_neg ? -dividend : dividend;
    assign dvs_mag = dvs_neg ? -divisor : divisor;

    // Bring in next two dividend bits
    assign rem_sh = {rem[`RV32M_WORD_SIZE-1:0], qd[`RV32M_WORD_SIZE-1 -: 2]};

    // Largest divisor multiple that fits
    always_comb begin
        if (rem_sh >= d3) begin
            q_digit  = 2'd3;
            rem_next = rem_sh - d3;
        end else if (rem_sh >= d2) begin
            q_digit  = 2'd2;
            rem_next = rem_sh - d2;
        end else if (rem_sh >= d1) begin
            q_digit  = 2'd1;
            rem_next = rem_sh - d1;
        end else begin
            q_digit  = 2'd0;
            rem_next = rem_sh;
        end
    end

    // Quotient sign from both operands, remainder follows dividend
    assign quot_fixed = q_neg ? -qd : qd;
    assign rem_fixed  = r_neg ? -rem[`RV32M_WORD_SIZE-1:0] : rem[`RV32M_WORD_SIZE-1:0];

    // Control FSM
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            step  <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (accept) begin
                        state <= BUSY;
                        step  <= '0;
                    end
                end
                BUSY: begin
                    step <= step + 1'b1;
                    if (step == LAST_STEP) begin
                        state <= SIGN_FIX;
                    end
                end
                SIGN_FIX: state <= DONE;
                default:  state <= IDLE;
            endcase
        end
    end

    // Datapath, divisor multiples fixed for the whole operation
    always_ff @(posedge CLK) begin
        if (accept) begin
            qd    <= dvd_mag;
            rem   <= '0;
            d1    <= rem_t'(dvs_mag);
            d2    <= rem_t'(dvs_mag) << 1;
            d3    <= rem_t'(dvs_mag) + (rem_t'(dvs_mag) << 1);
            q_neg <= dvd_neg ^ dvs_neg;
            r_neg <= dvd_neg;
        end else if (state == BUSY) begin
            qd  <= {qd[`RV32M_WORD_SIZE-3:0], q_digit};
            rem <= rem_next;
        end else if (state == SIGN_FIX) begin
            qd  <= quot_fixed;
            rem <= rem_t'(rem_fixed);
        end
    end

    assign quotient  = qd;
    assign remainder = rem[`RV32M_WORD_SIZE-1:0];
    assign finished  = (state == DONE);

endmodule

// File: rv32m_execute.sv
// RV32M execute block, reuses the last result, answers special cases and runs the two units
`timescale 1ns/1ps
`include "rv32m_consts.svh"

module rv32m_execute import rv32m_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      rv32m_start,
    input  rv32m_op_t operation,
    input  word_t     rv32m_a,
    input  word_t     rv32m_b,
    output logic      rv32m_done,
    output word_t     rv32m_out
);

    // Last completed request
    rv32m_op_t op_save;
    word_t a_save;
    word_t b_save;

    logic complete;
    logic new_req;
    logic launched;
    logic launch;

    // Operation decode
    logic is_multiply;
    sign_sel_t is_signed;

    // Special cases
    logic div_zero;
    logic overflow;
    logic special;

    // Unit interface
    logic mul_start;
    logic mul_finished;
    dword_t product;
    logic div_start;
    logic div_finished;
    word_t quotient;
    word_t remainder;
    logic unit_finished;

    assign complete = rv32m_start && rv32m_done;
    assign new_req  = (operation != op_save) || (rv32m_a != a_save) || (rv32m_b != b_save);

    // Save request at each completing edge
    // Reset value MUL 0 x 0 matches the cleared product
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            op_save <= MUL;
            a_save  <= '0;
            b_save  <= '0;
        end else if (complete) begin
            op_save <= operation;
            a_save  <= rv32m_a;
            b_save  <= rv32m_b;
        end
    end

    assign is_multiply = operation inside {MUL, MULH, MULHSU, MULHU};

    // Signedness per operation
    always_comb begin
        case (operation)
            MULHSU:            is_signed = 2'b10;
            MULHU, DIVU, REMU: is_signed = 2'b00;
            default:           is_signed = 2'b11;
        endcase
    end

    // Divide by zero for any divide, overflow only for signed forms
    assign div_zero = !is_multiply && (rv32m_b == '0);
    assign overflow = !is_multiply && is_signed[0]
                      && (rv32m_a == `RV32M_OVF_QUOT) && (rv32m_b == '1);
    assign special  = div_zero || overflow;

    // One start pulse per new request
    assign launch    = rv32m_start && new_req && !special && !launched;
    assign mul_start = launch && is_multiply;
    assign div_start = launch && !is_multiply;

    // Launched flag keeps a stale finished from counting
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            launched <= 1'b0;
        end else if (complete) begin
            launched <= 1'b0;
        end else if (launch) begin
            launched <= 1'b1;
        end
    end

    shift_add_multiplier mult_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .start        (mul_start),
        .multiplicand (rv32m_a),
        .multiplier   (rv32m_b),
        .is_signed    (is_signed),
        .product      (product),
        .finished     (mul_finished)
    );

    // DIV and REM forms are fully signed or fully unsigned, one bit is enough
    radix4_divider div_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .start     (div_start),
        .dividend  (rv32m_a),
        .divisor   (rv32m_b),
        .is_signed (is_signed[0]),
        .quotient  (quotient),
        .remainder (remainder),
        .finished  (div_finished)
    );

    assign unit_finished = is_multiply ? mul_finished : div_finished;

    // Done when idle, reused, special or unit back
    assign rv32m_done = !rv32m_start || !new_req || special || (launched && unit_finished);

    // Result select, zero while no request
    always_comb begin
        rv32m_out = '0;
        if (rv32m_start) begin
            case (operation)
                MUL: begin
                    rv32m_out = product[`RV32M_WORD_SIZE-1:0];
                end
                MULH, MULHSU, MULHU: begin
                    rv32m_out = product[2*`RV32M_WORD_SIZE-1:`RV32M_WORD_SIZE];
                end
                DIV, DIVU: begin
                    if (div_zero) begin
                        rv32m_out = `RV32M_DIVZ_QUOT;
                    end else if (overflow) begin
                        rv32m_out = `RV32M_OVF_QUOT;
                    end else begin
                        rv32m_out = quotient;
                    end
                end
                default: begin
                    // REM and REMU, dividend comes back on divide by zero
                    if (div_zero) begin
                        rv32m_out = rv32m_a;
                    end else if (overflow) begin
                        rv32m_out = `RV32M_OVF_REM;
                    end else begin
                        rv32m_out = remainder;
                    end
                end
            endcase
        end
    end

endmodule

// File: rv32m_assert.sv
// Protocol and unit start assertions, bound onto the execute block for simulation
`timescale 1ns/1ps

module rv32m_assert import rv32m_pkg::*; (
    input logic      CLK,
    input logic      nRST,
    input logic      rv32m_start,
    input logic      rv32m_done,
    input rv32m_op_t operation,
    input word_t     rv32m_a,
    input word_t     rv32m_b,
    input logic      mul_start,
    input logic      mul_finished,
    input logic      div_start,
    input logic      div_finished
);

    // Read by the testbench top
    int fail_count = 0;

    // A fresh start never sees the old finished
    mul_restart: assert property (@(posedge CLK) disable iff (!nRST)
        mul_start |=> !mul_finished)
        else begin
            fail_count++;
            $error("multiplier finished right after its start");
        end

    div_restart: assert property (@(posedge CLK) disable iff (!nRST)
        div_start |=> !div_finished)
        else begin
            fail_count++;
            $error("divider finished right after its start");
        end

    // Requester holds the request until completion
    held_request: assert property (@(posedge CLK) disable iff (!nRST)
        rv32m_start && !rv32m_done |=> rv32m_start && $stable(operation)
            && $stable(rv32m_a) && $stable(rv32m_b))
        else begin
            fail_count++;
            $error("request changed before it completed");
        end

endmodule

bind rv32m_execute rv32m_assert protocol_checks (
    .CLK          (CLK),
    .nRST         (nRST),
    .rv32m_start  (rv32m_start),
    .rv32m_done   (rv32m_done),
    .operation    (operation),
    .rv32m_a      (rv32m_a),
    .rv32m_b      (rv32m_b),
    .mul_start    (mul_start),
    .mul_finished (mul_finished),
    .div_start    (div_start),
    .div_finished (div_finished)
);

// File: rv32m_checker.sv
// Watches the execute block ports and compares every completed result with the RV32M reference
`timescale 1ns/1ps
`include "rv32m_consts.svh"

module rv32m_checker import rv32m_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      rv32m_start,
    input  rv32m_op_t operation,
    input  word_t     rv32m_a,
    input  word_t     rv32m_b,
    input  logic      rv32m_done,
    input  word_t     rv32m_out,
    output int        checks,
    output int        mismatches
);

    // Last completed request, MUL 0 x 0 after reset
    rv32m_op_t last_op;
    word_t last_a;
    word_t last_b;
    // Next sampled cycle opens a request
    logic first_cycle;
    logic same_req;
    logic special;
    word_t expected;

    // RV32M result from 64-bit arithmetic
    function automatic word_t reference(input rv32m_op_t op, input word_t a, input word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0] ua;
        logic [63:0] ub;
        logic [63:0] full;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        if ((op inside {DIV, DIVU, REM, REMU}) && b == '0) begin
            return (op inside {DIV, DIVU}) ? `RV32M_DIVZ_QUOT : a;
        end
        if ((op inside {DIV, REM}) && a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
            return (op == DIV) ? `RV32M_OVF_QUOT : '0;
        end
        case (op)
            MUL:     full = sa * sb;
            MULH:    full = (sa * sb) >> 32;
            MULHSU:  full = (sa * ub) >> 32;
            MULHU:   full = (ua * ub) >> 32;
            DIV:     full = sa / sb;
            DIVU:    full = ua / ub;
            REM:     full = sa % sb;
            default: full = ua % ub;
        endcase
        return full[31:0];
    endfunction

    task automatic report_mismatch(input string name, input word_t exp_val,
                                   input word_t act_val);
        $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                 $time, name, exp_val, act_val);
        mismatches++;
    endtask

    // Falling edge, inputs and outputs settled until the next rising edge
    always @(negedge CLK) begin
        if (!nRST) begin
            last_op     = MUL;
            last_a      = '0;
            last_b      = '0;
            first_cycle = 1'b1;
            checks      = 0;
            mismatches  = 0;
        end else begin
            same_req = (operation == last_op) && (rv32m_a == last_a) && (rv32m_b == last_b);
            special  = (operation inside {DIV, DIVU, REM, REMU}) && ((rv32m_b == '0)
                       || ((operation inside {DIV, REM}) && rv32m_a == 32'h8000_0000
                           && rv32m_b == 32'hFFFF_FFFF));
            if (!rv32m_start) begin
                // Idle outputs
                if (rv32m_done !== 1'b1) begin
                    report_mismatch("rv32m_done", 32'd1, word_t'(rv32m_done));
                end
                if (rv32m_out !== '0) begin
                    report_mismatch("rv32m_out", '0, rv32m_out);
                end
            end else begin
                // Reused or special requests finish in their first cycle, others later
                if (first_cycle && rv32m_done !== (same_req || special)) begin
                    report_mismatch("rv32m_done", word_t'(same_req || special),
                                    word_t'(rv32m_done));
                end
                if (rv32m_done === 1'b1) begin
                    expected = reference(operation, rv32m_a, rv32m_b);
                    checks++;
                    if (rv32m_out !== expected) begin
                        report_mismatch("rv32m_out", expected, rv32m_out);
                    end
                    last_op = operation;
                    last_a  = rv32m_a;
                    last_b  = rv32m_b;
                end
            end
            first_cycle = !rv32m_start || rv32m_done;
        end
    end

endmodule

// File: rv32m_tb.sv
// Testbench top for the RV32M execute block, runs directed and LFSR random requests and reports
`timescale 1ns/1ps

module rv32m_tb import rv32m_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int N_DIRECTED = 16;
    localparam int N_RANDOM = 150;
    // Random loop may repeat each request once
    localparam int NUM_TESTS = N_DIRECTED + 2 * N_RANDOM;
    // Unit latency plus gap stays well under 25 cycles per request
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 25 + RESET_CYCLES + 100;
    localparam logic [31:0] SEED = 32'd2516;
    // Galois taps for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic CLK;
    logic nRST;
    logic rv32m_start;
    rv32m_op_t operation;
    word_t rv32m_a;
    word_t rv32m_b;
    logic rv32m_done;
    word_t rv32m_out;

    int checks;
    int mismatches;
    int cycles;
    logic [31:0] lfsr;

    rv32m_execute uut (
        .CLK         (CLK),
        .nRST        (nRST),
        .rv32m_start (rv32m_start),
        .operation   (operation),
        .rv32m_a     (rv32m_a),
        .rv32m_b     (rv32m_b),
        .rv32m_done  (rv32m_done),
        .rv32m_out   (rv32m_out)
    );

    rv32m_checker checker_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .rv32m_start (rv32m_start),
        .operation   (operation),
        .rv32m_a     (rv32m_a),
        .rv32m_b     (rv32m_b),
        .rv32m_done  (rv32m_done),
        .rv32m_out   (rv32m_out),
        .checks      (checks),
        .mismatches  (mismatches)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // Mostly random, sometimes a corner value
    function automatic word_t pick_operand();
        logic [2:0] kind;
        kind = 3'(rand_bits(3));
        case (kind)
            3'd5:    return 32'h8000_0000;
            3'd6:    return 32'hFFFF_FFFF;
            3'd7:    return '0;
            default: return rand_bits(32);
        endcase
    endfunction

    // Entered and left on a rising edge, holds inputs until the completing edge
    task automatic run_request(input rv32m_op_t op, input word_t a, input word_t b,
                               input logic gap);
        if (gap) begin
            rv32m_start <= 1'b0;
            @(posedge CLK);
        end
        rv32m_start <= 1'b1;
        operation   <= op;
        rv32m_a     <= a;
        rv32m_b     <= b;
        do @(negedge CLK); while (rv32m_done !== 1'b1);
        @(posedge CLK);
    endtask

    task automatic print_counts();
        $display("checks=%0d mismatches=%0d assertion_failures=%0d cycles=%0d",
                 checks, mismatches, uut.protocol_checks.fail_count, cycles);
    endtask

    // Cycle limit against a hung request
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Timeout, requests did not complete within %0d cycles", cycles);
        print_counts();
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : stimulus
        rv32m_op_t op;
        word_t a;
        word_t b;
        logic gap;
        lfsr        = SEED;
        nRST        = 1'b0;
        rv32m_start = 1'b0;
        operation   = MUL;
        rv32m_a     = '0;
        rv32m_b     = '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
        // Idle cycles, done high and output zero
        repeat (3) @(posedge CLK);
        // Matches the saved request after reset
        run_request(MUL, '0, '0, 1'b0);
        // Divide by zero
        run_request(DIV, 32'h1234_5678, '0, 1'b0);
        run_request(DIVU, 32'hFFFF_FFF0, '0, 1'b0);
        run_request(REM, 32'h8765_4321, '0, 1'b1);
        run_request(REMU, 32'h0000_0042, '0, 1'b0);
        // Signed overflow, then the same operands unsigned
        run_request(DIV, 32'h8000_0000, 32'hFFFF_FFFF, 1'b1);
        run_request(REM, 32'h8000_0000, 32'hFFFF_FFFF, 1'b0);
        run_request(DIVU, 32'h8000_0000, 32'hFFFF_FFFF, 1'b0);
        // Negative dividend and divisor
        run_request(REM, 32'hFFFF_FF9C, 32'd7, 1'b0);
        run_request(DIV, 32'd100, 32'hFFFF_FFF9, 1'b1);
        // Reuse, then operation-only changes
        run_request(MUL, 32'hDEAD_BEEF, 32'h8000_0001, 1'b0);
        run_request(MUL, 32'hDEAD_BEEF, 32'h8000_0001, 1'b0);
        run_request(MULH, 32'hDEAD_BEEF, 32'h8000_0001, 1'b0);
        run_request(MULHSU, 32'hDEAD_BEEF, 32'h8000_0001, 1'b0);
        run_request(MULHU, 32'hDEAD_BEEF, 32'h8000_0001, 1'b0);
        run_request(MULHU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b1);
        for (int i = 0; i < N_RANDOM; i++) begin
            op  = rv32m_op_t'(3'(rand_bits(3)));
            a   = pick_operand();
            b   = pick_operand();
            gap = (rand_bits(1) != '0);
            run_request(op, a, b, gap);
            // Back-to-back repeat now and then
            if (rand_bits(2) == '0) begin
                run_request(op, a, b, 1'b0);
            end
        end
        rv32m_start <= 1'b0;
        repeat (4) @(posedge CLK);
        print_counts();
        if (mismatches == 0 && uut.protocol_checks.fail_count == 0 && checks > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: rv32m.f
+incdir+.
rv32m_pkg.sv
shift_add_multiplier.sv
radix4_divider.sv
rv32m_execute.sv
rv32m_assert.sv
rv32m_checker.sv
rv32m_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the RV32M execute testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rv32m_tb \
    -f rv32m.f

# Assertion errors are counted by the testbench instead of stopping the run
./obj_dir/Vrv32m_tb +verilator+error+limit+1000 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "run_sim: failure reported, see sim.log"
    exit 1
fi

echo "run_sim: no failure reported"
